/* bench/csr_unit_checker.sv */
`default_nettype none

module csr_unit_checker (
    input logic clk,
    input logic reset,
    input logic inst_valid,
    input logic rd_we,
    input logic redirect,
    input logic has_int
);
    timeunit 1ns;
    timeprecision 1ps;

    // a result and a redirect exclude each other
    assert property (@(posedge clk) disable iff (reset) !(rd_we && redirect))
        else $error("rd_we and redirect high together");

    assert property (@(posedge clk) disable iff (reset) rd_we |=> !rd_we)
        else $error("rd_we longer than one cycle");

    assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect)
        else $error("redirect longer than one cycle");

    // responses only in the cycle after a strobe
    assert property (@(posedge clk) disable iff (reset)
                     (rd_we || redirect) |-> $past(inst_valid))
        else $error("response without a strobe one cycle earlier");

    assert property (@(posedge clk) $past(reset) |-> !rd_we && !redirect && !has_int)
        else $error("outputs not low after reset");

endmodule

bind csr_unit csr_unit_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .rd_we      (rd_we),
    .redirect   (redirect),
    .has_int    (has_int)
);

`default_nettype wire

/* bench/csr_unit_tb.sv */
`default_nettype none

module csr_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    localparam word_t crmd_reset = 32'h0000_0008;   // only DA set
    localparam word_t inst_sys   = 32'h002b_0000;
    localparam word_t inst_brk   = 32'h002a_0000;
    localparam word_t inst_eret  = 32'h0648_3800;
    localparam word_t inst_bad   = 32'hffff_ffff;
    localparam int    wait_limit = 20;
    localparam int    poll_limit = 200;

    logic  clk, reset, inst_valid, fetch_adef, mem_ale;
    word_t inst, pc, rj_value, rkd_value, mem_vaddr;
    logic  rd_we, redirect, has_int;
    word_t rd_value, redirect_pc;

    word_t    lfsr = 32'h19e5;
    word_t    cur_pc = 32'h1c00_0000;
    word_t    issued_pc, got_value, old, v, m, w, exp_eentry, exp_crmd, saved_pc;
    logic     got_rd_we, got_redirect;
    int       errors, checks, tests, test_start, n;
    csr_num_t regs [7];
    word_t    model [7];

    csr_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one Galois step per bit taken
    function automatic word_t random_bits(input int count);
        word_t r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got == exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    // one strobe, then wait for the commit-cycle response
    task automatic issue(input word_t word, input word_t rj_v, input word_t rkd_v,
                         input logic adef, input logic ale, input word_t vaddr);
        int cnt;
        cnt        = 0;
        issued_pc  = cur_pc;
        pc         = cur_pc;
        cur_pc     = cur_pc + 4;
        inst       = word;
        rj_value   = rj_v;
        rkd_value  = rkd_v;
        fetch_adef = adef;
        mem_ale    = ale;
        mem_vaddr  = vaddr;
        inst_valid = 1'b1;
        @(negedge clk);
        inst_valid = 1'b0;
        fetch_adef = 1'b0;
        mem_ale    = 1'b0;
        while (!(rd_we || redirect) && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= wait_limit) begin
            $display("no rd_we or redirect after instruction %h", word);
            errors++;
        end
        got_rd_we    = rd_we;
        got_redirect = redirect;
        got_value    = rd_we ? rd_value : redirect_pc;
        @(negedge clk);   // leave the commit cycle
    endtask

    task automatic csr_access(input csr_num_t num, input logic [4:0] rj,
                              input word_t rj_v, input word_t rkd_v, output word_t prev);
        issue({8'h04, num, rj, 5'd4}, rj_v, rkd_v, 1'b0, 1'b0, '0);
        check("rd_we", 32'(got_rd_we), 32'd1);
        prev = got_value;
    endtask

    task automatic csrrd(input csr_num_t num, output word_t prev);
        csr_access(num, 5'd0, '0, '0, prev);
    endtask

    task automatic csrwr(input csr_num_t num, input word_t value, output word_t prev);
        csr_access(num, 5'd1, '0, value, prev);
    endtask

    task automatic csrxchg(input csr_num_t num, input word_t mask, input word_t value,
                           output word_t prev);
        csr_access(num, 5'd2, mask, value, prev);
    endtask

    task automatic trap(input word_t word, input logic adef, input logic ale,
                        input word_t vaddr, input word_t target);
        issue(word, '0, '0, adef, ale, vaddr);
        check("redirect", 32'(got_redirect), 32'd1);
        check("redirect_pc", got_value, target);
    endtask

    task automatic check_ecode(input word_t exp);
        csrrd(CSR_ESTAT, v);
        check("estat.ecode", 32'(v[21:16]), exp);
    endtask

    initial begin
        errors = 0; checks = 0; tests = 0; test_start = 0;
        reset = 1'b1; inst_valid = 1'b0; inst = '0; pc = '0;
        rj_value = '0; rkd_value = '0; mem_vaddr = '0; fetch_adef = 1'b0; mem_ale = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        check("has_int", 32'(has_int), 32'd0);
        csrrd(CSR_CRMD, v);  check("crmd", v, crmd_reset);
        csrrd(CSR_ECFG, v);  check("ecfg", v, 32'd0);
        csrrd(CSR_ESTAT, v); check("estat", v, 32'd0);
        csrrd(CSR_TVAL, v);  check("tval", v, 32'hffff_ffff);
        end_test("reset values");

        regs = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_ERA, CSR_ECFG};
        for (int i = 0; i < 7; i++) begin
            csrwr(regs[i], 32'h0, model[i]);   // learn the starting value
            model[i] = '0;
        end
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 7; i++) begin
                v = random_bits(32);
                m = random_bits(32);
                w = random_bits(32);
                csrwr(regs[i], v, old);
                check("rd_value csrwr", old, model[i]);
                model[i] = (regs[i] == CSR_ECFG) ? v & 32'h1bff : v;
                csrxchg(regs[i], m, w, old);
                check("rd_value csrxchg", old, model[i]);
                model[i] = (m & w) | (~m & model[i]);
                if (regs[i] == CSR_ECFG)
                    model[i] = model[i] & 32'h1bff;   // bit 10 reads zero
                csrrd(regs[i], old);
                check("read back", old, model[i]);
            end
        end
        csrwr(CSR_ECFG, 32'h0, old);
        exp_eentry = random_bits(32) & ~32'h3f;
        csrwr(CSR_EENTRY, exp_eentry | 32'h3f, old);
        csrrd(CSR_EENTRY, v); check("eentry", v, exp_eentry);
        end_test("masked access");

        csrwr(CSR_CRMD, 32'h7, old);   // plv 3, ie set
        trap(inst_sys, 1'b0, 1'b0, '0, exp_eentry);
        saved_pc = issued_pc;
        check_ecode(32'h0b);
        csrrd(CSR_ERA, v);  check("era", v, saved_pc);
        csrrd(CSR_PRMD, v); check("prmd", v, 32'h7);
        csrrd(CSR_CRMD, v); check("crmd", v, crmd_reset);
        trap(inst_eret, 1'b0, 1'b0, '0, saved_pc);
        csrrd(CSR_CRMD, v); check("crmd", v, crmd_reset | 32'h7);
        trap(inst_brk, 1'b0, 1'b0, '0, exp_eentry);
        saved_pc = issued_pc;
        check_ecode(32'h0c);
        trap(inst_eret, 1'b0, 1'b0, '0, saved_pc);
        end_test("syscall break ertn");

        csrwr(CSR_CRMD, 32'h0, old);
        trap({8'h04, CSR_SAVE0, 5'd0, 5'd4}, 1'b1, 1'b0, '0, exp_eentry);
        saved_pc = issued_pc;
        csrrd(CSR_ESTAT, v);
        check("estat.ecode", 32'(v[21:16]), 32'h08);
        check("estat.esubcode", 32'(v[30:22]), 32'h0);
        csrrd(CSR_BADV, v); check("badv", v, saved_pc);
        w = random_bits(32);
        trap({8'h04, CSR_SAVE0, 5'd0, 5'd4}, 1'b0, 1'b1, w, exp_eentry);
        check_ecode(32'h09);
        csrrd(CSR_BADV, v); check("badv", v, w);
        trap(inst_bad, 1'b0, 1'b0, '0, exp_eentry);
        check_ecode(32'h0d);
        trap(inst_sys, 1'b1, 1'b1, w, exp_eentry);
        saved_pc = issued_pc;
        check_ecode(32'h08);
        csrrd(CSR_BADV, v); check("badv", v, saved_pc);
        trap(inst_bad, 1'b0, 1'b1, w, exp_eentry);
        check_ecode(32'h0d);
        trap(inst_sys, 1'b0, 1'b1, w, exp_eentry);
        check_ecode(32'h0b);
        end_test("error classes");

        csrwr(CSR_TCFG, 32'h41, old);   // initval 0x10, one-shot
        csrrd(CSR_TVAL, v);
        checks++;
        assert (v < 32'h40) else begin
            $display("mismatch tval: got %h expected below %h", v, 32'h40);
            errors++;
        end
        n = 0;
        v = '0;
        while (!v[11] && n < poll_limit) begin
            csrrd(CSR_ESTAT, v);
            n++;
        end
        check("estat.ti", 32'(v[11]), 32'd1);
        csrwr(CSR_TICLR, 32'h1, old);
        csrrd(CSR_ESTAT, v); check("estat.ti", 32'(v[11]), 32'd0);
        csrwr(CSR_ECFG, 32'h800, old);
        csrwr(CSR_CRMD, 32'h4, old);
        csrwr(CSR_TCFG, 32'h41, old);
        n = 0;
        while (!has_int && n < poll_limit) begin
            @(negedge clk);
            n++;
        end
        check("has_int", 32'(has_int), 32'd1);
        trap({8'h04, CSR_SAVE0, 5'd0, 5'd4}, 1'b0, 1'b0, '0, exp_eentry);
        check_ecode(32'h00);
        csrrd(CSR_CRMD, v); check("crmd", v, crmd_reset);
        csrwr(CSR_TICLR, 32'h1, old);
        end_test("timer and interrupt");

        // strobe a write while the syscall redirect is out
        pc = cur_pc;
        inst = inst_sys;
        inst_valid = 1'b1;
        @(negedge clk);
        check("redirect", 32'(redirect), 32'd1);
        inst = {8'h04, CSR_SAVE0, 5'd1, 5'd4};
        rkd_value = ~model[0];
        @(negedge clk);
        inst_valid = 1'b0;
        check("rd_we", 32'(rd_we), 32'd0);
        check("redirect", 32'(redirect), 32'd0);
        @(negedge clk);
        csrrd(CSR_SAVE0, v); check("save0", v, model[0]);
        end_test("flush");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
rtl/csr_pkg.sv
rtl/csr_timer.sv
rtl/csr_decode.sv
rtl/csr_file.sv
rtl/csr_commit.sv
rtl/csr_unit.sv
bench/csr_unit_checker.sv
bench/csr_unit_tb.sv

/* rtl/csr_commit.sv */
`default_nettype none

module csr_commit (
    input  logic               clk,
    input  logic               reset,
    input  logic               dec_valid,
    input  logic               dec_ex,
    input  csr_pkg::ecode_t    dec_ecode,
    input  csr_pkg::esubcode_t dec_esubcode,
    input  logic               dec_ertn,
    input  logic               csr_re,
    input  csr_pkg::word_t     csr_rvalue,
    input  csr_pkg::word_t     pc,
    input  csr_pkg::word_t     mem_vaddr,
    input  csr_pkg::word_t     ex_entry,
    input  csr_pkg::word_t     ertn_entry,
    output logic               wb_ex,
    output csr_pkg::ecode_t    wb_ecode,
    output csr_pkg::esubcode_t wb_esubcode,
    output csr_pkg::word_t     wb_pc,
    output csr_pkg::word_t     wb_vaddr,
    output logic               ertn_flush,
    output logic               rd_we,
    output csr_pkg::word_t     rd_value,
    output logic               redirect,
    output csr_pkg::word_t     redirect_pc
);

    // valid bits of the single commit entry
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_we      <= 1'b0;
            wb_ex      <= 1'b0;
            ertn_flush <= 1'b0;
        end else begin
            rd_we      <= dec_valid && csr_re && !dec_ex;
            wb_ex      <= dec_valid && dec_ex;
            ertn_flush <= dec_valid && dec_ertn && !dec_ex;
        end
    end

    // payload, old CSR value captured before the write lands
    always_ff @(posedge clk) begin
        rd_value    <= csr_rvalue;
        wb_ecode    <= dec_ecode;
        wb_esubcode <= dec_esubcode;
        wb_pc       <= pc;
        wb_vaddr    <= mem_vaddr;
    end

    assign redirect    = wb_ex || ertn_flush;
    assign redirect_pc = wb_ex ? ex_entry : ertn_entry;

endmodule

`default_nettype wire

/* rtl/csr_decode.sv */
`default_nettype none

module csr_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_valid,
    input  csr_pkg::word_t     inst,
    input  csr_pkg::word_t     rj_value,
    input  csr_pkg::word_t     rkd_value,
    input  logic               fetch_adef,
    input  logic               mem_ale,
    input  logic               has_int,
    input  logic               flush,
    output csr_pkg::csr_num_t  csr_num,
    output logic               csr_re,
    output logic               csr_we,
    output csr_pkg::word_t     csr_wmask,
    output csr_pkg::word_t     csr_wvalue,
    output logic               dec_valid,
    output logic               dec_ex,
    output csr_pkg::ecode_t    dec_ecode,
    output csr_pkg::esubcode_t dec_esubcode,
    output logic               dec_ertn
);
    import csr_pkg::*;

    logic [4:0] rj;
    logic       is_csr;
    logic       is_csrrd;
    logic       is_csrwr;
    logic       is_ertn;
    logic       is_sys;
    logic       is_brk;
    logic       is_ine;

    assign rj       = inst[9:5];
    assign is_csr   = inst[31:24] == OP_CSR;
    assign is_csrrd = is_csr && rj == 5'd0;
    assign is_csrwr = is_csr && rj == 5'd1;   // any other rj is csrxchg
    assign is_ertn  = inst == INST_ERTN;
    assign is_sys   = inst[31:15] == OP_SYSCALL;
    assign is_brk   = inst[31:15] == OP_BREAK;
    assign is_ine   = !(is_csr || is_ertn || is_sys || is_brk);

    // older instruction in commit redirects, so this one is dropped
    assign dec_valid = inst_valid && !flush;
    assign dec_ex    = dec_valid && (has_int || fetch_adef || is_ine || is_sys
                                     || is_brk || mem_ale);
    assign dec_ertn  = dec_valid && is_ertn && !dec_ex;

    // INT, then ADEF, then INE/SYS/BRK, then ALE
    always_comb begin
        dec_esubcode = '0;
        if (has_int)
            dec_ecode = ECODE_INT;
        else if (fetch_adef) begin
            dec_ecode    = ECODE_ADE;
            dec_esubcode = ESUBCODE_ADEF;
        end else if (is_ine)
            dec_ecode = ECODE_INE;
        else if (is_sys)
            dec_ecode = ECODE_SYS;
        else if (is_brk)
            dec_ecode = ECODE_BRK;
        else
            dec_ecode = ECODE_ALE;
    end

    assign csr_num    = inst[23:10];
    assign csr_re     = dec_valid && is_csr && !dec_ex;
    assign csr_we     = csr_re && !is_csrrd;
    assign csr_wmask  = is_csrwr ? '1 : rj_value;   // csrxchg masks with rj
    assign csr_wvalue = rkd_value;

endmodule

`default_nettype wire

/* rtl/csr_file.sv */
`default_nettype none

module csr_file (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_num_t  csr_num,
    input  logic               csr_re,
    input  logic               csr_we,
    input  csr_pkg::word_t     csr_wmask,
    input  csr_pkg::word_t     csr_wvalue,
    input  logic               wb_ex,
    input  csr_pkg::ecode_t    wb_ecode,
    input  csr_pkg::esubcode_t wb_esubcode,
    input  csr_pkg::word_t     wb_pc,
    input  csr_pkg::word_t     wb_vaddr,
    input  logic               ertn_flush,
    output csr_pkg::word_t     csr_rvalue,
    output csr_pkg::word_t     ex_entry,
    output csr_pkg::word_t     ertn_entry,
    output logic               has_int
);
    import csr_pkg::*;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [12:0] ecfg_lie;
    logic [1:0]  estat_is_sw;     // software interrupt bits
    logic [12:0] estat_is;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    word_t       era;
    word_t       badv;
    logic [31:EENTRY_LOW_BITS] eentry_va;
    word_t       save [4];
    word_t       tid;
    word_t       crmd_data, prmd_data, ecfg_data, estat_data, eentry_data;
    word_t       crmd_next, prmd_next, ecfg_next, estat_next, eentry_next;
    word_t       tcfg_value, tval_value;
    logic        timer_int;
    word_t       rd_mux;

    function automatic word_t merged(input word_t old);
        return (csr_wmask & csr_wvalue) | (~csr_wmask & old);
    endfunction

    assign crmd_next   = merged(crmd_data);
    assign prmd_next   = merged(prmd_data);
    assign ecfg_next   = merged(ecfg_data);
    assign estat_next  = merged(estat_data);
    assign eentry_next = merged(eentry_data);

    // exception beats ertn, both beat a software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= CRMD_RESET_VALUE[1:0];
            crmd_ie  <= CRMD_RESET_VALUE[CRMD_IE_BIT];
        end else if (wb_ex) begin
            crmd_plv <= 2'd0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd_plv <= crmd_next[1:0];
            crmd_ie  <= crmd_next[CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            era       <= wb_pc;
        end else begin
            if (csr_we && csr_num == CSR_PRMD) begin
                prmd_pplv <= prmd_next[1:0];
                prmd_pie  <= prmd_next[2];
            end
            if (csr_we && csr_num == CSR_ERA)
                era <= merged(era);
        end
        if (wb_ex && (wb_ecode == ECODE_ADE || wb_ecode == ECODE_ALE))
            badv <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ? wb_pc : wb_vaddr;
        if (csr_we && csr_num == CSR_EENTRY)
            eentry_va <= eentry_next[31:EENTRY_LOW_BITS];
        for (int i = 0; i < 4; i++) begin
            if (csr_we && csr_num == CSR_SAVE0 + csr_num_t'(i))
                save[i] <= merged(save[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie       <= '0;
            estat_is_sw    <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            tid            <= '0;
        end else begin
            if (csr_we && csr_num == CSR_ECFG)
                ecfg_lie <= ecfg_next[12:0] & ECFG_LIE_MASK;
            if (csr_we && csr_num == CSR_ESTAT)
                estat_is_sw <= estat_next[1:0];
            if (wb_ex) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end
            if (csr_we && csr_num == CSR_TID)
                tid <= merged(tid);
        end
    end

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .tcfg_we    (csr_we && csr_num == CSR_TCFG),
        .ticlr_we   (csr_we && csr_num == CSR_TICLR),
        .wmask      (csr_wmask),
        .wvalue     (csr_wvalue),
        .tcfg_value (tcfg_value),
        .tval_value (tval_value),
        .timer_int  (timer_int)
    );

    always_comb begin
        estat_is               = '0;   // hw and ipi lines tied low
        estat_is[1:0]          = estat_is_sw;
        estat_is[ESTAT_TI_BIT] = timer_int;
    end

    assign crmd_data   = {CRMD_RESET_VALUE[31:3], crmd_ie, crmd_plv};
    assign prmd_data   = {29'd0, prmd_pie, prmd_pplv};
    assign ecfg_data   = {19'd0, ecfg_lie};
    assign estat_data  = {1'b0, estat_esubcode, estat_ecode, 3'd0, estat_is};
    assign eentry_data = {eentry_va, {EENTRY_LOW_BITS{1'b0}}};

    assign has_int    = (|(estat_is[11:0] & ecfg_lie[11:0])) && crmd_ie;
    assign ex_entry   = eentry_data;
    assign ertn_entry = era;

    always_comb begin
        case (csr_num)
            CSR_CRMD:   rd_mux = crmd_data;
            CSR_PRMD:   rd_mux = prmd_data;
            CSR_ECFG:   rd_mux = ecfg_data;
            CSR_ESTAT:  rd_mux = estat_data;
            CSR_ERA:    rd_mux = era;
            CSR_BADV:   rd_mux = badv;
            CSR_EENTRY: rd_mux = eentry_data;
            CSR_SAVE0:  rd_mux = save[0];
            CSR_SAVE1:  rd_mux = save[1];
            CSR_SAVE2:  rd_mux = save[2];
            CSR_SAVE3:  rd_mux = save[3];
            CSR_TID:    rd_mux = tid;
            CSR_TCFG:   rd_mux = tcfg_value;
            CSR_TVAL:   rd_mux = tval_value;
            default:    rd_mux = '0;    // TICLR and unknown read zero
        endcase
    end

    assign csr_rvalue = csr_re ? rd_mux : '0;

endmodule

`default_nettype wire

/* rtl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef logic [31:0] word_t;      // data word or address
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // CSR addresses
    localparam csr_num_t CSR_CRMD   = 14'h00;
    localparam csr_num_t CSR_PRMD   = 14'h01;
    localparam csr_num_t CSR_ECFG   = 14'h04;
    localparam csr_num_t CSR_ESTAT  = 14'h05;
    localparam csr_num_t CSR_ERA    = 14'h06;
    localparam csr_num_t CSR_BADV   = 14'h07;
    localparam csr_num_t CSR_EENTRY = 14'h0c;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    // field positions
    localparam int CRMD_IE_BIT       = 2;
    localparam int ESTAT_TI_BIT      = 11;   // timer interrupt status
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TICLR_CLR_BIT     = 0;
    localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;  // bit 10 reserved
    localparam int EENTRY_LOW_BITS   = 6;

    // only DA set, PLV 0, IE 0
    localparam word_t CRMD_RESET_VALUE = 32'h0000_0008;

    // exception codes
    localparam ecode_t    ECODE_INT     = 6'h00;
    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam ecode_t    ECODE_SYS     = 6'h0b;
    localparam ecode_t    ECODE_BRK     = 6'h0c;
    localparam ecode_t    ECODE_INE     = 6'h0d;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;

    // instruction encodings
    localparam logic [7:0]  OP_CSR     = 8'b0000_0100;
    localparam logic [16:0] OP_SYSCALL = 17'h00056;   // 0x002b0000 >> 15
    localparam logic [16:0] OP_BREAK   = 17'h00054;   // 0x002a0000 >> 15
    localparam word_t       INST_ERTN  = 32'h0648_3800;

endpackage

`default_nettype wire

/* rtl/csr_timer.sv */
`default_nettype none

module csr_timer (
    input  logic           clk,
    input  logic           reset,
    input  logic           tcfg_we,
    input  logic           ticlr_we,
    input  csr_pkg::word_t wmask,
    input  csr_pkg::word_t wvalue,
    output csr_pkg::word_t tcfg_value,
    output csr_pkg::word_t tval_value,
    output logic           timer_int
);
    import csr_pkg::*;

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    word_t       tcfg_next;
    word_t       timer_cnt;

    assign tcfg_value = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next  = (wmask & wvalue) | (~wmask & tcfg_value);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_we) begin
            tcfg_en       <= tcfg_next[TCFG_EN_BIT];
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_next[31:2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            timer_cnt <= '1;
        else if (tcfg_we && tcfg_next[TCFG_EN_BIT])
            timer_cnt <= {tcfg_next[31:2], 2'b00};   // initval times four
        else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b00};
            else
                timer_cnt <= timer_cnt - 32'd1;      // one-shot parks at all ones
        end
    end

    // set at zero, cleared by software through TICLR
    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (tcfg_en && timer_cnt == '0)
            timer_int <= 1'b1;
        else if (ticlr_we && wmask[TICLR_CLR_BIT] && wvalue[TICLR_CLR_BIT])
            timer_int <= 1'b0;
    end

    assign tval_value = timer_cnt;

endmodule

`default_nettype wire

/* rtl/csr_unit.sv */
`default_nettype none

module csr_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           inst_valid,
    input  csr_pkg::word_t inst,
    input  csr_pkg::word_t pc,
    input  csr_pkg::word_t rj_value,
    input  csr_pkg::word_t rkd_value,
    input  csr_pkg::word_t mem_vaddr,
    input  logic           fetch_adef,
    input  logic           mem_ale,
    output logic           rd_we,
    output csr_pkg::word_t rd_value,
    output logic           redirect,
    output csr_pkg::word_t redirect_pc,
    output logic           has_int
);
    import csr_pkg::*;

    csr_num_t  csr_num;
    logic      csr_re, csr_we;
    word_t     csr_wmask, csr_wvalue, csr_rvalue;
    logic      dec_valid, dec_ex, dec_ertn;
    ecode_t    dec_ecode, wb_ecode;
    esubcode_t dec_esubcode, wb_esubcode;
    logic      wb_ex, ertn_flush;
    word_t     wb_pc, wb_vaddr, ex_entry, ertn_entry;

    csr_decode u_decode (
        .clk (clk), .reset (reset), .inst_valid (inst_valid), .inst (inst),
        .rj_value (rj_value), .rkd_value (rkd_value), .fetch_adef (fetch_adef),
        .mem_ale (mem_ale), .has_int (has_int), .flush (redirect),
        .csr_num (csr_num), .csr_re (csr_re), .csr_we (csr_we),
        .csr_wmask (csr_wmask), .csr_wvalue (csr_wvalue), .dec_valid (dec_valid),
        .dec_ex (dec_ex), .dec_ecode (dec_ecode), .dec_esubcode (dec_esubcode),
        .dec_ertn (dec_ertn)
    );

    csr_commit u_commit (
        .clk (clk), .reset (reset), .dec_valid (dec_valid), .dec_ex (dec_ex),
        .dec_ecode (dec_ecode), .dec_esubcode (dec_esubcode), .dec_ertn (dec_ertn),
        .csr_re (csr_re), .csr_rvalue (csr_rvalue), .pc (pc), .mem_vaddr (mem_vaddr),
        .ex_entry (ex_entry), .ertn_entry (ertn_entry), .wb_ex (wb_ex),
        .wb_ecode (wb_ecode), .wb_esubcode (wb_esubcode), .wb_pc (wb_pc),
        .wb_vaddr (wb_vaddr), .ertn_flush (ertn_flush), .rd_we (rd_we),
        .rd_value (rd_value), .redirect (redirect), .redirect_pc (redirect_pc)
    );

    csr_file u_file (
        .clk (clk), .reset (reset), .csr_num (csr_num), .csr_re (csr_re),
        .csr_we (csr_we), .csr_wmask (csr_wmask), .csr_wvalue (csr_wvalue),
        .wb_ex (wb_ex), .wb_ecode (wb_ecode), .wb_esubcode (wb_esubcode),
        .wb_pc (wb_pc), .wb_vaddr (wb_vaddr), .ertn_flush (ertn_flush),
        .csr_rvalue (csr_rvalue), .ex_entry (ex_entry), .ertn_entry (ertn_entry),
        .has_int (has_int)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module csr_unit_tb \
    -o csr_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/csr_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0
